// File: sdram_defs.svh
//**************************************************************************
// sizes and timing constants of the SDRAM port
// geometry fixed to a 16-bit, 4-bank part with 13 row and 9 column bits
// INIT_WAIT is short for simulation, raise it for a real device (100 us)
// FIFO depth must be a power of two, 2 or more
//**************************************************************************
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// device geometry
`define SDRAM_ROW_W             13
`define SDRAM_COL_W             9
`define SDRAM_BANK_W            2
`define SDRAM_DQ_W              16

// timing, in clk cycles
`define SDRAM_INIT_WAIT         200   // power-up wait, 1 or more, max 65535
`define SDRAM_REFRESH_INTERVAL  512   // cycles between auto-refreshes

`define SDRAM_FIFO_DEPTH        4     // request queue entries

// mode register: single-location bursts off, CAS 2, sequential, burst of 2
`define SDRAM_MODE_WORD         13'b000_0_00_010_0_001

`endif

// File: sdram_pkg.sv
//**************************************************************************
// shared types of the SDRAM port
// req_t layout, msb first: write flag, word address, strobes, data
// waddr_t is {bank, row, column[8:1]}, column bit 0 is always zero
//**************************************************************************
`include "sdram_defs.svh"

package sdram_pkg;
    typedef logic [31:0] word_t;  // host data word
    typedef logic [3:0]  strb_t;  // byte enables
    typedef logic [`SDRAM_BANK_W+`SDRAM_ROW_W+`SDRAM_COL_W-2:0] waddr_t;
    typedef logic [$bits(waddr_t)+$bits(strb_t)+$bits(word_t):0] req_t;

    // {cs_n, ras_n, cas_n, we_n}
    typedef logic [3:0] sdram_cmd_t;
    localparam sdram_cmd_t CMD_MODE      = 4'b0000;
    localparam sdram_cmd_t CMD_REFRESH   = 4'b0001;
    localparam sdram_cmd_t CMD_PRECHARGE = 4'b0010;
    localparam sdram_cmd_t CMD_ACTIVATE  = 4'b0011;
    localparam sdram_cmd_t CMD_WRITE     = 4'b0100;
    localparam sdram_cmd_t CMD_READ      = 4'b0101;
    localparam sdram_cmd_t CMD_NOP       = 4'b0111;

    typedef enum logic [2:0] {
        st_init_wait, st_init_cmd, st_idle, st_access, st_refresh
    } seq_state_t;
endpackage

// File: sdram_axil_port.sv
//**************************************************************************
// AXI4-Lite slave front end of the SDRAM port
// responses are always OKAY, PROT is not present
// byte address bits 24:2 select the word, all other bits are ignored
// one read outstanding at a time, writes need AW and W in the same cycle
//**************************************************************************
`timescale 1ns/1ps

module sdram_axil_port (
    input  logic             clk,
    input  logic             rst,
    // write address / data / response
    input  logic [31:0]      awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  logic [31:0]      wdata,
    input  logic [3:0]       wstrb,
    input  logic             wvalid,
    output logic             wready,
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  logic             bready,
    // read address / data
    input  logic [31:0]      araddr,
    input  logic             arvalid,
    output logic             arready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  logic             rready,
    // request queue side
    output logic             push,
    output sdram_pkg::req_t  push_data,
    input  logic             full,
    // read return from the sequencer
    input  logic             rd_valid,
    input  sdram_pkg::word_t rd_data
);
    import sdram_pkg::*;

    logic   wr_go;       // AW+W taken this cycle
    logic   rd_go;       // AR taken this cycle
    logic   rd_pending;  // read queued, data not back yet
    waddr_t aw_word;
    waddr_t ar_word;

    assign aw_word = awaddr[24:2];
    assign ar_word = araddr[24:2];

    // both write beats must be there, and the last response must be gone
    assign wr_go = awvalid && wvalid && !bvalid && !full;

    // single push port, a write wins the cycle
    assign rd_go = arvalid && !rd_pending && !rvalid && !full && !wr_go;

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    assign push = wr_go || rd_go;

    always_comb begin
        if (wr_go) begin
            push_data = {1'b1, aw_word, wstrb, wdata};
        end else begin
            // read: strobes all on, no data
            push_data = {1'b0, ar_word, strb_t'('1), word_t'('0)};
        end
    end

    assign bresp = 2'b00;  // OKAY
    assign rresp = 2'b00;

    // write response, up the cycle after the push
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_go) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // read tracking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pending <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            if (rd_go) begin
                rd_pending <= 1'b1;
            end else if (rd_valid) begin
                rd_pending <= 1'b0;  // data back from the sequencer
            end
            if (rd_valid) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read data held with rvalid
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rdata <= rd_data;
        end
    end

endmodule

// File: sdram_req_fifo.sv
//**************************************************************************
// request queue between the AXI4-Lite port and the sequencer
// depth from SDRAM_FIFO_DEPTH, a power of two of 2 or more
// push while full and pop while empty are ignored
// head_data is valid whenever empty is low
//**************************************************************************
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_req_fifo (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  sdram_pkg::req_t push_data,
    output logic            full,
    input  logic            pop,
    output sdram_pkg::req_t head_data,
    output logic            empty
);
    import sdram_pkg::*;

    localparam int DEPTH = `SDRAM_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    req_t        mem [DEPTH];
    logic [AW:0] wr_ptr;  // msb is the wrap bit
    logic [AW:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    // same slot, other lap
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign head_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

endmodule

// File: sdram_sequencer.sv
//**************************************************************************
// SDRAM command sequencer: init, auto-refresh and 8-cycle access slots
// every access is ACTIVATE then READ/WRITE with auto-precharge, so all
// banks are idle between slots; burst of 2 beats at CAS latency 2
// assumes a 16-bit data bus and a column of 10 bits or less
// refresh is due every REFRESH_INTERVAL cycles and wins over a request
//**************************************************************************
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    // request queue
    input  logic                     empty,
    input  sdram_pkg::req_t          head_data,
    output logic                     pop,
    // read return
    output logic                     rd_valid,
    output sdram_pkg::word_t         rd_data,
    output logic                     init_done,
    // SDRAM pins
    inout  wire  [`SDRAM_DQ_W-1:0]   sdram_dq,
    output logic [`SDRAM_ROW_W-1:0]  sdram_a,
    output logic [`SDRAM_BANK_W-1:0] sdram_ba,
    output logic                     sdram_cs_n,
    output logic                     sdram_ras_n,
    output logic                     sdram_cas_n,
    output logic                     sdram_we_n,
    output logic [1:0]               sdram_dqm,
    output logic                     sdram_cke
);
    import sdram_pkg::*;

    localparam int BW    = `SDRAM_BANK_W;
    localparam int RW    = `SDRAM_ROW_W;
    localparam int CW    = `SDRAM_COL_W;
    localparam int REF_W = $clog2(`SDRAM_REFRESH_INTERVAL + 1);
    // NOP gaps after init commands
    localparam logic [15:0] GAP_RP  = 16'd2;  // precharge
    localparam logic [15:0] GAP_RFC = 16'd8;  // auto-refresh
    localparam logic [15:0] GAP_MRD = 16'd2;  // mode load

    seq_state_t       state;
    sdram_cmd_t       cmd;
    logic [15:0]      wait_cnt;   // init wait and gaps
    logic [2:0]       init_step;
    logic [2:0]       slot_cnt;   // cycle within access/refresh slot
    logic [REF_W-1:0] ref_cnt;
    logic             ref_due;
    logic             dq_oe;
    logic [15:0]      dq_out;
    logic [15:0]      rd_lo;      // first read beat

    logic   head_wr;
    waddr_t head_addr;
    strb_t  head_strb;
    word_t  head_wdata;

    // request in service, caught at pop
    logic          cur_wr;
    logic [CW-2:0] cur_colhi;
    strb_t         cur_strb;
    word_t         cur_wdata;

    assign {head_wr, head_addr, head_strb, head_wdata} = head_data;
    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
    assign sdram_cke = 1'b1;
    assign sdram_dq  = dq_oe ? dq_out : 'z;  // driven in write beats only

    assign ref_due = (ref_cnt == REF_W'(`SDRAM_REFRESH_INTERVAL));
    // pop registers together with ACTIVATE
    assign pop = (state == st_idle) && !empty && !ref_due;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_init_wait;
            cmd       <= CMD_NOP;
            wait_cnt  <= 16'(`SDRAM_INIT_WAIT - 1);
            init_step <= '0;
            slot_cnt  <= '0;
            ref_cnt   <= '0;
            init_done <= 1'b0;
            rd_valid  <= 1'b0;
            dq_oe     <= 1'b0;
            sdram_a   <= '0;
            sdram_ba  <= '0;
            sdram_dqm <= 2'b11;  // masked through power-up
        end else begin
            cmd      <= CMD_NOP;
            rd_valid <= 1'b0;
            if (init_done && !ref_due) begin
                ref_cnt <= ref_cnt + 1'b1;  // saturates at due
            end
            case (state)
                st_init_wait: begin
                    if (wait_cnt != 16'd0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else begin
                        state <= st_init_cmd;
                    end
                end
                st_init_cmd: begin
                    if (wait_cnt != 16'd0) begin
                        wait_cnt <= wait_cnt - 1'b1;  // NOP gap
                    end else begin
                        init_step <= init_step + 1'b1;
                        case (init_step)
                            3'd0: begin
                                cmd         <= CMD_PRECHARGE;
                                sdram_a[10] <= 1'b1;  // all banks
                                wait_cnt    <= GAP_RP;
                            end
                            3'd1, 3'd2: begin
                                cmd      <= CMD_REFRESH;
                                wait_cnt <= GAP_RFC;
                            end
                            3'd3: begin
                                cmd      <= CMD_MODE;
                                sdram_a  <= `SDRAM_MODE_WORD;
                                sdram_ba <= '0;
                                wait_cnt <= GAP_MRD;
                            end
                            default: begin
                                init_done <= 1'b1;
                                sdram_dqm <= 2'b00;
                                state     <= st_idle;
                            end
                        endcase
                    end
                end
                st_idle: begin
                    slot_cnt <= '0;
                    if (ref_due) begin
                        cmd     <= CMD_REFRESH;
                        ref_cnt <= '0;
                        state   <= st_refresh;
                    end else if (!empty) begin
                        cmd      <= CMD_ACTIVATE;
                        sdram_ba <= head_addr[BW+RW+CW-2 -: BW];
                        sdram_a  <= head_addr[RW+CW-2 -: RW];  // row
                        state    <= st_access;
                    end
                end
                st_access: begin
                    slot_cnt <= slot_cnt + 1'b1;
                    case (slot_cnt)
                        3'd1: begin
                            cmd              <= cur_wr ? CMD_WRITE : CMD_READ;
                            sdram_a          <= '0;
                            sdram_a[10]      <= 1'b1;  // auto-precharge
                            sdram_a[CW-1:0]  <= {cur_colhi, 1'b0};
                            dq_oe            <= cur_wr;
                            // low beat mask, strobe 0 masks the byte
                            sdram_dqm <= cur_wr ? ~cur_strb[1:0] : 2'b00;
                        end
                        3'd2: sdram_dqm <= cur_wr ? ~cur_strb[3:2] : 2'b00;
                        3'd3: begin
                            dq_oe     <= 1'b0;
                            sdram_dqm <= 2'b00;
                        end
                        3'd5: rd_valid <= !cur_wr;  // high in cycle 6
                        3'd7: state <= st_idle;
                        default: ;
                    endcase
                end
                st_refresh: begin
                    slot_cnt <= slot_cnt + 1'b1;
                    if (slot_cnt == 3'd7) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_init_wait;
            endcase
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (pop) begin
            cur_wr    <= head_wr;
            cur_colhi <= head_addr[CW-2:0];
            cur_strb  <= head_strb;
            cur_wdata <= head_wdata;
        end
        if (state == st_access) begin
            if (slot_cnt == 3'd1) begin
                dq_out <= cur_wdata[15:0];   // beat 0 with WRITE
            end
            if (slot_cnt == 3'd2) begin
                dq_out <= cur_wdata[31:16];
            end
            if (slot_cnt == 3'd4 && !cur_wr) begin
                rd_lo <= sdram_dq;
            end
            if (slot_cnt == 3'd5 && !cur_wr) begin
                rd_data <= {sdram_dq, rd_lo};  // low beat first
            end
        end
    end

endmodule

// File: sdram_top.sv
//**************************************************************************
// SDRAM port top: AXI4-Lite slave, request queue, command sequencer
// requests made during init wait in the queue until init_done
// SDRAM clock is clk, phase alignment is left to the board
//**************************************************************************
`timescale 1ns/1ps
`include "sdram_defs.svh"

module sdram_top (
    input  logic                     clk,
    input  logic                     rst,
    // AXI4-Lite slave
    input  logic [31:0]              awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [31:0]              araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // SDRAM pins
    inout  wire  [`SDRAM_DQ_W-1:0]   sdram_dq,
    output logic [`SDRAM_ROW_W-1:0]  sdram_a,
    output logic [`SDRAM_BANK_W-1:0] sdram_ba,
    output logic                     sdram_cs_n,
    output logic                     sdram_ras_n,
    output logic                     sdram_cas_n,
    output logic                     sdram_we_n,
    output logic [1:0]               sdram_dqm,
    output logic                     sdram_cke,
    output logic                     init_done
);
    import sdram_pkg::*;

    logic  push;       // port to queue
    req_t  push_data;
    logic  full;
    logic  pop;        // queue to sequencer
    req_t  head_data;
    logic  empty;
    logic  rd_valid;   // read return
    word_t rd_data;

    // names line up, so implicit connections
    sdram_axil_port i_port (.*);
    sdram_req_fifo  i_fifo (.*);
    sdram_sequencer i_seq  (.*);

endmodule

// File: tb_clk_gen.sv
//**************************************************************************
// testbench clock and reset, 8 ns period
// rst high for the first 2 rising edges, released 1 ns after the second
//**************************************************************************
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 125 MHz
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end
endmodule

// File: tb_sdram_model.sv
//**************************************************************************
// behavioral SDRAM for the testbench, burst of 2 at CAS latency 2 only
// words never written read back as zero
// a protocol error raises proto_err, the testbench ends the run on it
//**************************************************************************
`timescale 1ns/1ps
`include "sdram_defs.svh"

module tb_sdram_model (
    input  logic                     clk,
    inout  wire  [`SDRAM_DQ_W-1:0]   dq,
    input  logic [`SDRAM_ROW_W-1:0]  a,
    input  logic [`SDRAM_BANK_W-1:0] ba,
    input  logic                     cs_n,
    input  logic                     ras_n,
    input  logic                     cas_n,
    input  logic                     we_n,
    input  logic [1:0]               dqm,
    output logic                     proto_err,
    output int                       refresh_cnt
);
    import sdram_pkg::*;

    sdram_cmd_t  cmd;
    logic        mode_set = 1'b0;
    logic [3:0]  row_open = '0;         // one bit per bank
    logic [12:0] open_row [4];
    logic [15:0] store [int];           // sparse, key {bank, row, col}
    logic        wr_beat1 = 1'b0;       // second write beat due
    int          wr_key;
    logic [1:0]  rd_stage = '0;         // read return pipeline
    int          rd_key;
    logic [15:0] drv;
    logic        oe = 1'b0;

    assign cmd = {cs_n, ras_n, cas_n, we_n};
    assign dq  = oe ? drv : 'z;

    initial begin
        proto_err   = 1'b0;
        refresh_cnt = 0;
    end

    function automatic logic [15:0] fetch(input int key);
        return store.exists(key) ? store[key] : 16'h0000;
    endfunction

    // byte writes under dqm, a high mask bit keeps the byte
    task automatic write_beat(input int key, input logic [15:0] d, input logic [1:0] m);
        logic [15:0] w;
        w = fetch(key);
        if (!m[0]) w[7:0] = d[7:0];
        if (!m[1]) w[15:8] = d[15:8];
        store[key] = w;
    endtask

    task automatic flag_error(input string msg);
        $display("SDRAM model protocol error at %0t ns: %s", $time, msg);
        proto_err <= 1'b1;
    endtask

    always @(posedge clk) begin
        if (wr_beat1) begin
            write_beat(wr_key + 1, dq, dqm);
            wr_beat1 <= 1'b0;
        end
        case (rd_stage)
            2'd1: begin
                drv      <= fetch(rd_key);  // beat 0, sampled 2 edges after READ
                oe       <= 1'b1;
                rd_stage <= 2'd2;
            end
            2'd2: begin
                drv      <= fetch(rd_key + 1);
                rd_stage <= 2'd3;
            end
            2'd3: begin
                oe       <= 1'b0;
                rd_stage <= 2'd0;
            end
            default: ;
        endcase
        case (cmd)
            CMD_MODE: mode_set <= 1'b1;
            CMD_REFRESH: refresh_cnt <= refresh_cnt + 1;
            CMD_PRECHARGE: begin
                if (a[10]) row_open <= '0;
                else row_open[ba] <= 1'b0;
            end
            CMD_ACTIVATE: begin
                if (!mode_set) flag_error("ACTIVATE before mode load");
                else if (row_open[ba]) flag_error("ACTIVATE to a bank with an open row");
                row_open[ba] <= 1'b1;
                open_row[ba] <= a;
            end
            CMD_WRITE, CMD_READ: begin
                if (!mode_set) flag_error("READ or WRITE before mode load");
                else if (!row_open[ba]) flag_error("READ or WRITE to a bank with no open row");
                if (cmd == CMD_WRITE) begin
                    wr_key = (int'(ba) << 22) | (int'(open_row[ba]) << 9) | int'(a[8:0]);
                    write_beat(wr_key, dq, dqm);  // beat 0 comes with the command
                    wr_beat1 <= 1'b1;
                end else begin
                    rd_key   = (int'(ba) << 22) | (int'(open_row[ba]) << 9) | int'(a[8:0]);
                    rd_stage <= 2'd1;
                end
                if (a[10]) row_open[ba] <= 1'b0;  // auto-precharge
            end
            default: ;
        endcase
    end
endmodule

// File: tb_sdram_top.sv
//**************************************************************************
// testbench of the SDRAM port with a table of requests applied in a loop
// rready stays high and bready drops only in the back-pressure entry
// only one AXI request is in flight from the host side at any time
//**************************************************************************
`timescale 1ns/1ps
`include "sdram_defs.svh"

module tb_sdram_top;
    import sdram_pkg::*;

    localparam int NE     = 15;
    localparam int OP_WR  = 0;
    localparam int OP_RD  = 1;
    localparam int OP_BP  = 2;  // eight writes under back-pressure and their read-back
    localparam int REF_GAP = 4 * `SDRAM_REFRESH_INTERVAL;

    logic clk, rst;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;
    wire  [`SDRAM_DQ_W-1:0]   sdram_dq;
    logic [`SDRAM_ROW_W-1:0]  sdram_a;
    logic [`SDRAM_BANK_W-1:0] sdram_ba;
    logic sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n, sdram_cke, init_done;
    logic [1:0] sdram_dqm;
    logic proto_err;
    int   refresh_cnt;

    int     t_op [NE];
    waddr_t t_addr [NE];
    word_t  t_data [NE];
    strb_t  t_strb [NE];
    int     t_gap [NE];
    word_t  ref_mem [int];       // reference memory keyed by word address
    logic [31:0] lcg_state = 32'h7dad;
    int     limit_cycles = 0;
    logic   table_ready = 1'b0;

    tb_clk_gen i_clk (.clk(clk), .rst(rst));

    sdram_top i_dut (.*);

    tb_sdram_model i_model (
        .clk(clk), .dq(sdram_dq), .a(sdram_a), .ba(sdram_ba), .cs_n(sdram_cs_n),
        .ras_n(sdram_ras_n), .cas_n(sdram_cas_n), .we_n(sdram_we_n), .dqm(sdram_dqm),
        .proto_err(proto_err), .refresh_cnt(refresh_cnt)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic word_t merge(input word_t old, input word_t nw, input strb_t s);
        word_t r;
        for (int b = 0; b < 4; b++) r[8*b +: 8] = s[b] ? nw[8*b +: 8] : old[8*b +: 8];
        return r;
    endfunction

    function automatic word_t expect_word(input waddr_t wa);
        return ref_mem.exists(int'(wa)) ? ref_mem[int'(wa)] : 32'h0;
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_entry(input int i, input int op, input waddr_t wa, input strb_t s,
                             input int gap);
        t_op[i]   = op;
        t_addr[i] = wa;
        t_data[i] = lcg_next();
        t_strb[i] = s;
        t_gap[i]  = gap;
    endtask

    // write handshake with inputs driven 1 ns after the edge
    task automatic axi_write(input waddr_t wa, input word_t d, input strb_t s);
        awaddr  = {7'h0, wa, 2'b00};
        wdata   = d;
        wstrb   = s;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge clk); while (!awready);
        check_val(wready, 1'b1, "wready together with awready");
        ref_mem[int'(wa)] = merge(expect_word(wa), d, s);
        #1 awvalid = 1'b0;
        wvalid = 1'b0;
        do @(posedge clk); while (!bvalid);
        check_val(bresp, 2'b00, "write response");
        #1;
    endtask

    task automatic axi_read(input waddr_t wa);
        araddr  = {7'h0, wa, 2'b00};
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        #1 arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        check_val(rdata, expect_word(wa), $sformatf("read data at word %h", wa));
        check_val(rresp, 2'b00, "read response");
        #1;
    endtask

    // the first write goes in and its held bvalid blocks the rest
    task automatic write_flood(input waddr_t base);
        waddr_t wa [8];
        word_t  d;
        bready = 1'b0;
        for (int i = 0; i < 8; i++) begin
            wa[i]   = base + waddr_t'(i << 8);  // next row each time
            d       = lcg_next();
            awaddr  = {7'h0, wa[i], 2'b00};
            wdata   = d;
            wstrb   = 4'hf;
            awvalid = 1'b1;
            wvalid  = 1'b1;
            if (i == 1) begin
                repeat (4) begin
                    @(posedge clk);
                    check_val(awready, 1'b0, "awready low while bvalid held");
                    check_val(wready, 1'b0, "wready low while bvalid held");
                end
                #1 bready = 1'b1;
            end
            do @(posedge clk); while (!awready);
            ref_mem[int'(wa[i])] = d;
            #1;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (int i = 0; i < 8; i++) axi_read(wa[i]);
    endtask

    // pin-side checks
    always @(posedge clk) begin
        if (!rst) begin
            check_val(sdram_cke, 1'b1, "cke held high");
            if ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} == CMD_ACTIVATE) begin
                check_val(init_done, 1'b1, "init_done high at ACTIVATE");
            end
        end
    end

    always @(posedge proto_err) begin
        $display("the SDRAM model saw an illegal command order");
        $display("TEST RESULT: FAIL");
        $fatal(1, "protocol error");
    end

    initial begin
        wait (table_ready);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: the run took longer than %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        int r0;
        awaddr  = '0;
        wdata   = '0;
        wstrb   = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        bready  = 1'b1;
        rready  = 1'b1;
        // entry, op, {bank, row, col}, strobes, gap
        add_entry(0,  OP_WR, {2'd0, 13'h0001, 8'h04}, 4'hf, 0);  // queued during init
        add_entry(1,  OP_RD, {2'd0, 13'h0001, 8'h04}, 4'hf, 0);
        add_entry(2,  OP_WR, {2'd1, 13'h1abc, 8'h22}, 4'hf, 3);
        add_entry(3,  OP_WR, {2'd3, 13'h0fff, 8'hff}, 4'hf, 0);
        add_entry(4,  OP_RD, {2'd1, 13'h1abc, 8'h22}, 4'hf, 0);
        add_entry(5,  OP_RD, {2'd3, 13'h0fff, 8'hff}, 4'hf, 5);
        add_entry(6,  OP_WR, {2'd1, 13'h1abc, 8'h22}, 4'b0101, 0);  // partial
        add_entry(7,  OP_RD, {2'd1, 13'h1abc, 8'h22}, 4'hf, 0);
        add_entry(8,  OP_WR, {2'd2, 13'h0300, 8'h10}, 4'b1000, 0);
        add_entry(9,  OP_RD, {2'd2, 13'h0300, 8'h10}, 4'hf, 0);
        add_entry(10, OP_RD, {2'd0, 13'h0001, 8'h04}, 4'hf, REF_GAP);
        add_entry(11, OP_RD, {2'd3, 13'h0fff, 8'hff}, 4'hf, 0);  // intact after refresh
        add_entry(12, OP_BP, {2'd2, 13'h0100, 8'h40}, 4'hf, 0);
        add_entry(13, OP_WR, {2'd3, 13'h0042, 8'h08}, 4'hf, 0);
        add_entry(14, OP_RD, {2'd3, 13'h0042, 8'h08}, 4'hf, 0);  // right behind the write
        limit_cycles = NE * 40 + `SDRAM_INIT_WAIT;
        for (int i = 0; i < NE; i++) limit_cycles += t_gap[i];
        table_ready = 1'b1;

        @(negedge rst);
        @(posedge clk);
        #1;
        for (int i = 0; i < NE; i++) begin
            case (t_op[i])
                OP_WR: axi_write(t_addr[i], t_data[i], t_strb[i]);
                OP_RD: axi_read(t_addr[i]);
                default: write_flood(t_addr[i]);
            endcase
            r0 = refresh_cnt;
            repeat (t_gap[i]) @(posedge clk);
            if (t_gap[i] > 0) #1;
            if (t_gap[i] >= REF_GAP)
                check_val(32'(refresh_cnt - r0 >= 3), 1, "auto-refreshes during idle gap");
        end
        $display("TEST RESULT: PASS");
        $finish;
    end
endmodule

// File: files.f
+incdir+.
sdram_pkg.sv
sdram_axil_port.sv
sdram_req_fifo.sv
sdram_sequencer.sv
sdram_top.sv
tb_clk_gen.sv
tb_sdram_model.sv
tb_sdram_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SDRAM port testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_sdram_top -f files.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
